// ==== rtl/audio_reader_pkg.sv ====
package audio_reader_pkg;

    // Chunk layout from the memory read path
    localparam int CHUNK_W           = 152;
    localparam int ADDR_W            = 24;    // Top bits of the chunk
    localparam int SAMPLE_W          = 16;
    localparam int SAMPLES_PER_CHUNK = 8;     // Sample 0 in the low bits

    // Width of the sample period input
    localparam int PERIOD_W = 14;

    typedef logic [CHUNK_W-1:0] chunk_t;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef enum logic {
        UNSTACK_EMPTY,    // Waiting for a chunk
        UNSTACK_EMIT      // Handing out samples
    } unstack_state_t;

endpackage

// ==== rtl/chunk_fifo.sv ====
`timescale 1ns/1ps

module chunk_fifo
    #(
        parameter int FIFO_DEPTH = 16
    )
    (
        input  wire                      clk,
        input  wire                      rst_n,

        input  wire                      in_valid,
        output logic                     in_ready,
        input  wire audio_reader_pkg::chunk_t in_data,

        output logic                     out_valid,
        input  wire                      out_ready,
        output audio_reader_pkg::chunk_t out_data
    );

    import audio_reader_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

    chunk_t           mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != FULL_CNT);
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_data  = mem[rd_ptr];    // Head of queue, shown as soon as count is nonzero

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle, or read and write together
            endcase
        end
    end

endmodule

// ==== rtl/instrument_router.sv ====
`timescale 1ns/1ps

module instrument_router
    #(
        parameter int INSTRUMENT_COUNT = 2
    )
    (
        input  wire                               head_valid,
        input  wire [audio_reader_pkg::ADDR_W-1:0] head_addr,
        output logic                              head_ready,

        input  wire [audio_reader_pkg::ADDR_W-1:0] addr_offsets [INSTRUMENT_COUNT:0],
        input  wire                               addr_offsets_valid,

        output logic [INSTRUMENT_COUNT-1:0]       route_valid,
        input  wire  [INSTRUMENT_COUNT-1:0]       unstack_ready
    );

    logic [INSTRUMENT_COUNT-1:0] match;
    logic                        any_match;

    // Window i covers offset i up to, not including, offset i+1
    always_comb begin
        for (int i = 0; i < INSTRUMENT_COUNT; i++) begin
            match[i] = addr_offsets_valid &&
                       (head_addr >= addr_offsets[i]) &&
                       (head_addr < addr_offsets[i+1]);
        end
    end

    assign any_match   = |match;
    assign route_valid = match & {INSTRUMENT_COUNT{head_valid}};

    // Unmatched chunks are popped and dropped
    assign head_ready = any_match ? |(match & unstack_ready) : 1'b1;

endmodule

// ==== rtl/chunk_unstacker.sv ====
`timescale 1ns/1ps

module chunk_unstacker
    (
        input  wire  clk,
        input  wire  rst_n,

        input  wire  chunk_valid,
        output logic chunk_ready,
        input  wire  [audio_reader_pkg::SAMPLES_PER_CHUNK*audio_reader_pkg::SAMPLE_W-1:0]
                     chunk_samples,

        output logic samp_valid,
        input  wire  samp_ready,
        output audio_reader_pkg::sample_t samp_data
    );

    import audio_reader_pkg::*;

    localparam int IDX_W = $clog2(SAMPLES_PER_CHUNK);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(SAMPLES_PER_CHUNK - 1);

    unstack_state_t                            state;
    logic [SAMPLES_PER_CHUNK*SAMPLE_W-1:0]     chunk_q;
    logic [IDX_W-1:0]                          idx;
    logic                                      chunk_accept;
    logic                                      samp_accept;

    assign chunk_ready  = (state == UNSTACK_EMPTY);
    assign samp_valid   = (state == UNSTACK_EMIT);
    assign chunk_accept = chunk_valid && chunk_ready;
    assign samp_accept  = samp_valid && samp_ready;
    assign samp_data    = sample_t'(chunk_q[idx*SAMPLE_W +: SAMPLE_W]);

    always_ff @(posedge clk) begin
        if (chunk_accept) chunk_q <= chunk_samples;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= UNSTACK_EMPTY;
            idx   <= '0;
        end else begin
            case (state)
                UNSTACK_EMPTY: begin
                    if (chunk_accept) begin
                        state <= UNSTACK_EMIT;
                        idx   <= '0;    // Sample 0 goes out first
                    end
                end
                UNSTACK_EMIT: begin
                    if (samp_accept) begin
                        if (idx == LAST_IDX) begin
                            state <= UNSTACK_EMPTY;
                            idx   <= '0;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default: state <= UNSTACK_EMPTY;
            endcase
        end
    end

endmodule

// ==== rtl/sample_period_timer.sv ====
`timescale 1ns/1ps

module sample_period_timer
    (
        input  wire                                 clk,
        input  wire                                 rst_n,
        input  wire [audio_reader_pkg::PERIOD_W-1:0] sample_period,
        output logic                                tick
    );

    import audio_reader_pkg::*;

    logic [PERIOD_W-1:0] count;

    // Count runs P down to 1, so a new period only loads at the wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            tick <= 1'b0;
            if (count == '0) begin
                count <= sample_period;    // Stays idle while period is zero
            end else if (count == PERIOD_W'(1)) begin
                tick  <= 1'b1;
                count <= sample_period;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/sample_mixer.sv ====
`timescale 1ns/1ps

module sample_mixer
    #(
        parameter int INSTRUMENT_COUNT = 2
    )
    (
        input  wire                        clk,
        input  wire                        rst_n,
        input  wire                        tick,

        input  wire audio_reader_pkg::sample_t din [INSTRUMENT_COUNT-1:0],
        input  wire  [INSTRUMENT_COUNT-1:0] din_valid,
        output logic [INSTRUMENT_COUNT-1:0] din_ready,

        output audio_reader_pkg::sample_t  dout,
        output logic                       dout_valid
    );

    import audio_reader_pkg::*;

    // Room for the worst case sum of all instruments
    localparam int SUM_W = SAMPLE_W + $clog2(INSTRUMENT_COUNT) + 1;
    localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'((1 <<< (SAMPLE_W - 1)) - 1);
    localparam logic signed [SUM_W-1:0] SAT_MIN = SUM_W'(-(1 <<< (SAMPLE_W - 1)));

    logic signed [SUM_W-1:0] sum;
    sample_t                 sum_sat;

    assign din_ready = {INSTRUMENT_COUNT{tick}};    // Every instrument drains on a tick

    always_comb begin
        sum = '0;
        for (int i = 0; i < INSTRUMENT_COUNT; i++) begin
            if (din_valid[i]) sum = sum + din[i];    // Missing data counts as silence
        end
    end

    always_comb begin
        if (sum > SAT_MAX) begin
            sum_sat = sample_t'(SAT_MAX);
        end else if (sum < SAT_MIN) begin
            sum_sat = sample_t'(SAT_MIN);
        end else begin
            sum_sat = sum[SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout       <= '0;
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= tick;
            if (tick) dout <= sum_sat;
        end
    end

endmodule

// ==== rtl/dram_reader_audio.sv ====
`timescale 1ns/1ps

module dram_reader_audio
    #(
        parameter int INSTRUMENT_COUNT = 2,
        parameter int FIFO_DEPTH       = 16
    )
    (
        input  wire                                 clk,
        input  wire                                 rst_n,

        input  wire [audio_reader_pkg::PERIOD_W-1:0] sample_period,
        input  wire [audio_reader_pkg::ADDR_W-1:0]   addr_offsets [INSTRUMENT_COUNT:0],
        input  wire                                 addr_offsets_valid,
        output audio_reader_pkg::sample_t           sample,
        output logic                                sample_valid,

        input  wire                                 chunk_valid,
        output logic                                chunk_ready,
        input  wire audio_reader_pkg::chunk_t       chunk_data
    );

    import audio_reader_pkg::*;

    logic                        head_valid;
    logic                        head_ready;
    chunk_t                      head_data;

    logic [INSTRUMENT_COUNT-1:0] route_valid;
    logic [INSTRUMENT_COUNT-1:0] unstack_ready;

    logic [INSTRUMENT_COUNT-1:0] samp_valid;
    logic [INSTRUMENT_COUNT-1:0] samp_ready;
    sample_t                     samp_data [INSTRUMENT_COUNT-1:0];

    logic                        tick;

    chunk_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) dram_read_fifo (
        .clk(clk),
        .rst_n(rst_n),
        .in_valid(chunk_valid),
        .in_ready(chunk_ready),
        .in_data(chunk_data),
        .out_valid(head_valid),
        .out_ready(head_ready),
        .out_data(head_data)
    );

    instrument_router #(
        .INSTRUMENT_COUNT(INSTRUMENT_COUNT)
    ) router (
        .head_valid(head_valid),
        .head_addr(head_data[CHUNK_W-1 -: ADDR_W]),    // Address sits above the samples
        .head_ready(head_ready),
        .addr_offsets(addr_offsets),
        .addr_offsets_valid(addr_offsets_valid),
        .route_valid(route_valid),
        .unstack_ready(unstack_ready)
    );

    for (genvar i = 0; i < INSTRUMENT_COUNT; i++) begin : gen_unstack
        chunk_unstacker dram_read_unstacker (
            .clk(clk),
            .rst_n(rst_n),
            .chunk_valid(route_valid[i]),
            .chunk_ready(unstack_ready[i]),
            .chunk_samples(head_data[SAMPLES_PER_CHUNK*SAMPLE_W-1:0]),
            .samp_valid(samp_valid[i]),
            .samp_ready(samp_ready[i]),
            .samp_data(samp_data[i])
        );
    end

    sample_period_timer timer (
        .clk(clk),
        .rst_n(rst_n),
        .sample_period(sample_period),
        .tick(tick)
    );

    sample_mixer #(
        .INSTRUMENT_COUNT(INSTRUMENT_COUNT)
    ) mixer (
        .clk(clk),
        .rst_n(rst_n),
        .tick(tick),
        .din(samp_data),
        .din_valid(samp_valid),
        .din_ready(samp_ready),
        .dout(sample),
        .dout_valid(sample_valid)
    );

endmodule

// ==== verification/dram_reader_audio_sva.sv ====
`timescale 1ns/1ps

module dram_reader_audio_sva
    #(
        parameter int FIFO_DEPTH = 16
    )
    (
        input wire                                  clk,
        input wire                                  rst_n,
        input wire                                  chunk_valid,
        input wire                                  chunk_ready,
        input wire audio_reader_pkg::chunk_t        chunk_data,
        input wire                                  sample_valid,
        input wire [audio_reader_pkg::PERIOD_W-1:0] sample_period,
        input wire                                  head_pop
    );

    logic [$clog2(FIFO_DEPTH+1)-1:0] occupancy;    // Chunks in flight between the two ports
    logic                            push;

    assign push = chunk_valid && chunk_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupancy <= '0;
        end else begin
            if (push && !head_pop) begin
                occupancy <= occupancy + 1'b1;
            end else if (!push && head_pop) begin
                occupancy <= occupancy - 1'b1;
            end
        end
    end

    chunk_held: assert property (@(posedge clk) disable iff (!rst_n)
        chunk_valid && !chunk_ready |=> $stable(chunk_data))
        else $error("chunk_data changed while waiting for chunk_ready");

    valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid && (sample_period > 1) |=> !sample_valid)
        else $error("sample_valid high on two cycles in a row");

    valid_in_reset: assert property (@(posedge clk) !rst_n |-> !sample_valid)
        else $error("sample_valid high during reset");

    ready_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (occupancy == FIFO_DEPTH) |-> !chunk_ready)
        else $error("chunk_ready high while the FIFO is full");

endmodule

bind dram_reader_audio dram_reader_audio_sva #(.FIFO_DEPTH(FIFO_DEPTH)) sva_inst (
    .clk(clk),
    .rst_n(rst_n),
    .chunk_valid(chunk_valid),
    .chunk_ready(chunk_ready),
    .chunk_data(chunk_data),
    .sample_valid(sample_valid),
    .sample_period(sample_period),
    .head_pop(head_valid && head_ready)
);

// ==== verification/dram_reader_audio_tb.sv ====
`timescale 1ns/1ps

module dram_reader_audio_tb;

    import audio_reader_pkg::*;

    localparam int INSTR   = 2;
    localparam int TIMEOUT = 2000;    // Cycles allowed per wait

    logic                clk;
    logic                rst_n;
    logic [PERIOD_W-1:0] sample_period;
    logic [ADDR_W-1:0]   addr_offsets [INSTR:0];
    logic                addr_offsets_valid;
    sample_t             sample;
    logic                sample_valid;
    logic                chunk_valid;
    logic                chunk_ready;
    chunk_t              chunk_data;

    chunk_t chunk_tab [16];
    int     n_chunks;
    string  row_name [8];
    int     row_first [8];
    int     row_count [8];
    int     row_period [8];
    logic   row_offs_valid [8];
    int     row_ticks [8];    // Pulses checked before the timer is stopped
    logic   row_ready_exp [8];
    int     n_rows;
    int     exp_samp [INSTR][64];
    int     exp_len [INSTR];
    int     seed = 32'hfe5a;
    int     mismatch_count = 0;
    int     timeout_count = 0;

    dram_reader_audio #(
        .INSTRUMENT_COUNT(INSTR),
        .FIFO_DEPTH(4)
    ) dram_reader_audio_inst (
        .clk(clk),
        .rst_n(rst_n),
        .sample_period(sample_period),
        .addr_offsets(addr_offsets),
        .addr_offsets_valid(addr_offsets_valid),
        .sample(sample),
        .sample_valid(sample_valid),
        .chunk_valid(chunk_valid),
        .chunk_ready(chunk_ready),
        .chunk_data(chunk_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_sample(input string test, input sample_t exp, input sample_t act);
        if (exp !== act) begin
            $display("Mismatch in %s: sample expected %0d, got %0d", test, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string test, input string flag, input logic exp,
                              input logic act);
        if (exp !== act) begin
            $display("Mismatch in %s: %s expected %0b, got %0b", test, flag, exp, act);
            mismatch_count++;
        end
    endtask

    function automatic logic [127:0] rand_samples();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic add_row(input string name, input int period, input logic offs_valid,
                           input int ticks, input logic ready_exp);
        row_name[n_rows]       = name;
        row_first[n_rows]      = n_chunks;
        row_count[n_rows]      = 0;
        row_period[n_rows]     = period;
        row_offs_valid[n_rows] = offs_valid;
        row_ticks[n_rows]      = ticks;
        row_ready_exp[n_rows]  = ready_exp;
        n_rows++;
    endtask

    task automatic add_chunk(input logic [ADDR_W-1:0] addr, input logic [127:0] samples);
        chunk_tab[n_chunks] = {addr, samples};
        n_chunks++;
        row_count[n_rows-1]++;
    endtask

    task automatic load_table();
        add_row("single_inst0", 16, 1'b1, 10, 1'b1);
        add_chunk(24'h000100, rand_samples());
        add_row("interleaved", 20, 1'b1, 17, 1'b1);
        add_chunk(24'h000200, rand_samples());
        add_chunk(24'h001200, rand_samples());
        add_chunk(24'h000fff, rand_samples());
        add_chunk(24'h001ffe, rand_samples());
        add_row("saturate", 16, 1'b1, 9, 1'b1);
        add_chunk(24'h000040, {16'h0000, 16'h7fff, -16'sd100, 16'sd100,
                               -16'sd30000, 16'sd30000, 16'h8000, 16'h7fff});
        add_chunk(24'h001040, {16'h0000, 16'h7fff, 16'h8000, 16'h7fff,
                               -16'sd5000, 16'sd5000, -16'sd1, 16'sd1});
        add_row("unmapped_addr", 16, 1'b1, 4, 1'b1);
        add_chunk(24'h003000, rand_samples());
        add_row("offsets_invalid", 16, 1'b0, 4, 1'b1);
        add_chunk(24'h000100, rand_samples());
        add_row("backpressure", 17, 1'b1, 25, 1'b0);    // Two unstackers plus four FIFO slots
        for (int c = 0; c < 6; c++) add_chunk(c[0] ? 24'h001800 : 24'h000800, rand_samples());
    endtask

    // Sample j of a chunk sits at bits j*16, windows are [offset i, offset i+1)
    task automatic build_model(input int r);
        logic [ADDR_W-1:0] addr;
        for (int i = 0; i < INSTR; i++) exp_len[i] = 0;
        for (int c = row_first[r]; c < row_first[r] + row_count[r]; c++) begin
            addr = chunk_tab[c][CHUNK_W-1 -: ADDR_W];
            for (int i = 0; i < INSTR; i++) begin
                if (row_offs_valid[r] && addr >= addr_offsets[i] && addr < addr_offsets[i+1]) begin
                    for (int j = 0; j < SAMPLES_PER_CHUNK; j++) begin
                        exp_samp[i][exp_len[i]] = int'(sample_t'(chunk_tab[c][j*16 +: 16]));
                        exp_len[i]++;
                    end
                end
            end
        end
    endtask

    function automatic sample_t expected_at(input int k);
        int sum;
        sum = 0;
        for (int i = 0; i < INSTR; i++) begin
            if (k < exp_len[i]) sum += exp_samp[i][k];    // Exhausted queue adds silence
        end
        if (sum > 32767) sum = 32767;
        else if (sum < -32768) sum = -32768;
        return sample_t'(sum);
    endfunction

    task automatic push_chunk(input string test, input chunk_t data);
        int waited;
        waited      = 0;
        chunk_valid = 1'b1;
        chunk_data  = data;
        while (!chunk_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (chunk_ready) begin
            @(negedge clk);    // Transfer on the rising edge in between
        end else begin
            $display("Timeout in %s: chunk was never accepted", test);
            timeout_count++;
        end
        chunk_valid = 1'b0;
    endtask

    task automatic wait_sample(input string test, output bit ok);
        int waited;
        waited = 0;
        while (!sample_valid && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        ok = sample_valid;
        if (!ok) begin
            $display("Timeout in %s: no sample_valid pulse arrived", test);
            timeout_count++;
        end
    endtask

    task automatic run_row(input int r);
        bit ok;
        build_model(r);
        addr_offsets_valid = row_offs_valid[r];
        for (int c = row_first[r]; c < row_first[r] + row_count[r]; c++) begin
            push_chunk(row_name[r], chunk_tab[c]);
        end
        check_flag(row_name[r], "chunk_ready", row_ready_exp[r], chunk_ready);
        sample_period = PERIOD_W'(row_period[r]);
        for (int k = 0; k <= row_ticks[r]; k++) begin
            if (k == row_ticks[r]) sample_period = '0;    // One trailing tick, then idle
            wait_sample(row_name[r], ok);
            if (ok) check_sample(row_name[r], expected_at(k), sample);
            @(negedge clk);
        end
    endtask

    initial begin
        bit idle_pulse;
        rst_n              = 1'b0;
        sample_period      = '0;
        addr_offsets_valid = 1'b0;
        chunk_valid        = 1'b0;
        chunk_data         = '0;
        addr_offsets[0]    = 24'h000000;
        addr_offsets[1]    = 24'h001000;
        addr_offsets[2]    = 24'h002000;
        n_rows             = 0;
        n_chunks           = 0;
        idle_pulse         = 1'b0;
        load_table();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_flag("reset_idle", "sample_valid", 1'b0, sample_valid);
        check_flag("reset_idle", "chunk_ready", 1'b1, chunk_ready);
        repeat (40) begin
            @(negedge clk);
            idle_pulse |= sample_valid;    // Timer must stay quiet with period 0
        end
        check_flag("reset_idle", "sample_valid seen", 1'b0, idle_pulse);
        for (int r = 0; r < n_rows; r++) run_row(r);
        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/audio_reader_pkg.sv
rtl/chunk_fifo.sv
rtl/instrument_router.sv
rtl/chunk_unstacker.sv
rtl/sample_period_timer.sv
rtl/sample_mixer.sv
rtl/dram_reader_audio.sv
verification/dram_reader_audio_sva.sv
verification/dram_reader_audio_tb.sv
